// File: common/core_pkg.sv
package core_pkg;

	// datapath width
	localparam int XLEN = 32;

	// data or address word
	typedef logic [XLEN-1:0] word_t;
	// register index
	typedef logic [4:0] reg_idx_t;
	// alu operation code
	typedef logic [3:0] alu_op_t;

	// alu operations
	localparam alu_op_t ALU_ADD    = 4'd0;
	localparam alu_op_t ALU_SUB    = 4'd1;
	localparam alu_op_t ALU_SLT    = 4'd2;
	localparam alu_op_t ALU_XOR    = 4'd3;
	localparam alu_op_t ALU_OR     = 4'd4;
	localparam alu_op_t ALU_AND    = 4'd5;
	// lui path, operand b goes straight through
	localparam alu_op_t ALU_PASS_B = 4'd6;

	// major opcodes, low two bits included
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;

	// funct3 codes for the supported subset
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;
	localparam logic [2:0] F3_BEQ     = 3'b000;
	localparam logic [2:0] F3_BNE     = 3'b001;
	localparam logic [2:0] F3_JALR    = 3'b000;

	// funct7 codes for register-register ops
	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_SUB  = 7'b0100000;

	// operand b sources
	localparam logic [1:0] SRC_B_REG  = 2'd0;
	localparam logic [1:0] SRC_B_IMM  = 2'd1;
	localparam logic [1:0] SRC_B_STEP = 2'd2;

	// fetch address after reset
	localparam word_t RESET_PC  = 32'h8000_0000;
	// sequential pc increment, also the link offset
	localparam word_t INST_STEP = 32'd4;

	// decoder to datapath control bundle
	typedef struct packed {
		reg_idx_t   rd;
		reg_idx_t   rs1;
		reg_idx_t   rs2;
		word_t      imm;
		alu_op_t    alu_op;
		logic       src_a_pc;
		logic [1:0] src_b_sel;
		logic       reg_write;
		logic       is_branch;
		logic       branch_ne;
		logic       is_jal;
		logic       is_jalr;
		logic       illegal;
	} ctrl_t;

	// register write trace
	typedef struct packed {
		logic     valid;
		reg_idx_t rd;
		word_t    data;
	} commit_t;

endpackage

// File: decode/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
	input  core_pkg::word_t inst,
	output core_pkg::ctrl_t ctrl
);
	import core_pkg::*;

	// raw instruction fields
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;

	// sign-extended immediates per format
	word_t imm_i;
	word_t imm_u;
	word_t imm_j;
	word_t imm_b;

	// opcode class writes a register, before the rd and illegal filter
	logic writes_rd;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	// i-type, 12 bits from the top
	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	// u-type, upper 20 bits with low zeros
	assign imm_u = {inst[31:12], 12'b0};
	// j-type, scrambled 20-bit offset in halfwords
	assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
	// b-type, scrambled 12-bit offset in halfwords
	assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};

	always_comb begin
		// default is a harmless add with no side effects
		ctrl           = '0;
		ctrl.rd        = inst[11:7];
		ctrl.rs1       = inst[19:15];
		ctrl.rs2       = inst[24:20];
		ctrl.alu_op    = ALU_ADD;
		ctrl.src_b_sel = SRC_B_REG;
		writes_rd      = 1'b0;

		case (opcode)
			OPC_OP_IMM: begin
				ctrl.imm       = imm_i;
				ctrl.src_b_sel = SRC_B_IMM;
				writes_rd      = 1'b1;
				// shifts and sltiu are not supported
				case (funct3)
					F3_ADD_SUB: ctrl.alu_op = ALU_ADD;
					F3_SLT:     ctrl.alu_op = ALU_SLT;
					F3_XOR:     ctrl.alu_op = ALU_XOR;
					F3_OR:      ctrl.alu_op = ALU_OR;
					F3_AND:     ctrl.alu_op = ALU_AND;
					default:    ctrl.illegal = 1'b1;
				endcase
			end
			OPC_OP: begin
				writes_rd = 1'b1;
				// funct7 and funct3 together pick the op
				case ({funct7, funct3})
					{F7_BASE, F3_ADD_SUB}: ctrl.alu_op = ALU_ADD;
					{F7_SUB, F3_ADD_SUB}:  ctrl.alu_op = ALU_SUB;
					{F7_BASE, F3_SLT}:     ctrl.alu_op = ALU_SLT;
					{F7_BASE, F3_XOR}:     ctrl.alu_op = ALU_XOR;
					{F7_BASE, F3_OR}:      ctrl.alu_op = ALU_OR;
					{F7_BASE, F3_AND}:     ctrl.alu_op = ALU_AND;
					default:               ctrl.illegal = 1'b1;
				endcase
			end
			OPC_LUI: begin
				// immediate passes through the alu
				ctrl.imm       = imm_u;
				ctrl.src_b_sel = SRC_B_IMM;
				ctrl.alu_op    = ALU_PASS_B;
				writes_rd      = 1'b1;
			end
			OPC_AUIPC: begin
				ctrl.imm       = imm_u;
				ctrl.src_a_pc  = 1'b1;
				ctrl.src_b_sel = SRC_B_IMM;
				writes_rd      = 1'b1;
			end
			OPC_JAL: begin
				// link value is pc plus 4 through the alu
				ctrl.imm       = imm_j;
				ctrl.src_a_pc  = 1'b1;
				ctrl.src_b_sel = SRC_B_STEP;
				ctrl.is_jal    = 1'b1;
				writes_rd      = 1'b1;
			end
			OPC_JALR: begin
				ctrl.imm       = imm_i;
				ctrl.src_a_pc  = 1'b1;
				ctrl.src_b_sel = SRC_B_STEP;
				// only funct3 000 is defined
				if (funct3 == F3_JALR) begin
					ctrl.is_jalr = 1'b1;
					writes_rd    = 1'b1;
				end else begin
					ctrl.illegal = 1'b1;
				end
			end
			OPC_BRANCH: begin
				ctrl.imm = imm_b;
				// beq and bne only
				case (funct3)
					F3_BEQ:  ctrl.is_branch = 1'b1;
					F3_BNE: begin
						ctrl.is_branch = 1'b1;
						ctrl.branch_ne = 1'b1;
					end
					default: ctrl.illegal = 1'b1;
				endcase
			end
			default: ctrl.illegal = 1'b1;
		endcase

		// no write for x0 or for anything unknown
		ctrl.reg_write = writes_rd && !ctrl.illegal && (ctrl.rd != '0);
	end

endmodule

// File: execute/execute_unit.sv
`timescale 1ns/1ps

module execute_unit (
	input  core_pkg::ctrl_t ctrl,
	input  core_pkg::word_t pc,
	input  core_pkg::word_t rs1_data,
	input  core_pkg::word_t rs2_data,
	output core_pkg::word_t result,
	output logic            take_target,
	output core_pkg::word_t target
);
	import core_pkg::*;

	// alu operands
	word_t op_a;
	word_t op_b;
	// base and raw sum for the jump target
	word_t jump_base;
	word_t jump_sum;
	// branch compare
	logic  rs_equal;
	logic  branch_taken;

	// pc for auipc and the link value
	assign op_a = ctrl.src_a_pc ? pc : rs1_data;

	always_comb begin
		case (ctrl.src_b_sel)
			SRC_B_REG:  op_b = rs2_data;
			SRC_B_IMM:  op_b = ctrl.imm;
			SRC_B_STEP: op_b = INST_STEP;
			default:    op_b = '0;
		endcase
	end

	// alu
	always_comb begin
		case (ctrl.alu_op)
			ALU_ADD:    result = op_a + op_b;
			ALU_SUB:    result = op_a - op_b;
			// signed compare, 1 or 0
			ALU_SLT:    result = word_t'($signed(op_a) < $signed(op_b));
			ALU_XOR:    result = op_a ^ op_b;
			ALU_OR:     result = op_a | op_b;
			ALU_AND:    result = op_a & op_b;
			ALU_PASS_B: result = op_b;
			default:    result = '0;
		endcase
	end

	// beq and bne share one comparator
	assign rs_equal     = (rs1_data == rs2_data);
	assign branch_taken = ctrl.is_branch && (rs_equal ^ ctrl.branch_ne);

	// jalr is register relative, jal and branches are pc relative
	assign jump_base = ctrl.is_jalr ? rs1_data : pc;
	assign jump_sum  = jump_base + ctrl.imm;

	// bit 0 cleared for jalr only
	assign target = {jump_sum[XLEN-1:1], jump_sum[0] & ~ctrl.is_jalr};

	// redirect on any jump or a taken branch
	assign take_target = ctrl.is_jal || ctrl.is_jalr || branch_taken;

endmodule

// File: source/core_top.sv
`timescale 1ns/1ps

module core_top (
	input  logic              clk,
	input  logic              arst_n,
	input  core_pkg::word_t   inst,
	output core_pkg::word_t   pc,
	output core_pkg::commit_t commit,
	output logic              illegal
);
	import core_pkg::*;

	// decoded control for the current instruction
	ctrl_t ctrl;
	// register read data
	word_t rs1_data;
	word_t rs2_data;
	// alu result, also the write-back value
	word_t result;
	// redirect request from execute
	logic  take_target;
	word_t target;

	// fetch address register
	pc_unit u_pc_unit (
		.clk         (clk),
		.arst_n      (arst_n),
		.take_target (take_target),
		.target      (target),
		.pc          (pc)
	);

	// fields, immediates and control
	inst_decoder u_inst_decoder (
		.inst (inst),
		.ctrl (ctrl)
	);

	// x1..x31, written at the end of the cycle
	register_file u_register_file (
		.clk      (clk),
		.arst_n   (arst_n),
		.rs1      (ctrl.rs1),
		.rs2      (ctrl.rs2),
		.rd       (ctrl.rd),
		.write    (ctrl.reg_write),
		.wdata    (result),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data)
	);

	// operand muxes, alu and jump target
	execute_unit u_execute_unit (
		.ctrl        (ctrl),
		.pc          (pc),
		.rs1_data    (rs1_data),
		.rs2_data    (rs2_data),
		.result      (result),
		.take_target (take_target),
		.target      (target)
	);

	// trace of the write that lands on the coming edge
	// reg_write is already low for x0 and illegal encodings
	assign commit = '{valid: ctrl.reg_write, rd: ctrl.rd, data: result};

	// unsupported encoding flag
	assign illegal = ctrl.illegal;

endmodule

// File: source/pc_unit.sv
`timescale 1ns/1ps

module pc_unit (
	input  logic            clk,
	input  logic            arst_n,
	input  logic            take_target,
	input  core_pkg::word_t target,
	output core_pkg::word_t pc
);
	import core_pkg::*;

	// sequential fetch address
	word_t pc_seq;
	// address for the next cycle
	word_t pc_next;

	// fall-through path
	assign pc_seq = pc + INST_STEP;

	// jumps and taken branches override the fall-through
	// illegal encodings never set take_target so they step by 4
	assign pc_next = take_target ? target : pc_seq;

	// one new pc per clock
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			// boot address
			pc <= RESET_PC;
		end else begin
			pc <= pc_next;
		end
	end

endmodule

// File: source/register_file.sv
`timescale 1ns/1ps

module register_file (
	input  logic              clk,
	input  logic              arst_n,
	input  core_pkg::reg_idx_t rs1,
	input  core_pkg::reg_idx_t rs2,
	input  core_pkg::reg_idx_t rd,
	input  logic              write,
	input  core_pkg::word_t   wdata,
	output core_pkg::word_t   rs1_data,
	output core_pkg::word_t   rs2_data
);
	import core_pkg::*;

	// x1..x31, x0 has no storage
	word_t regs [1:31];

	// whole file clears on reset
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (write && (rd != '0)) begin
			// x0 writes dropped here as well
			regs[rd] <= wdata;
		end
	end

	// combinational reads, no bypass
	// a write shows up the cycle after its edge
	assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
	assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: verification/core_assertions.sv
`timescale 1ns/1ps

module core_assertions (
	input logic              clk,
	input logic              arst_n,
	input core_pkg::word_t   pc,
	input core_pkg::commit_t commit,
	input logic              illegal
);
	import core_pkg::*;

	// x0 writes are filtered before the commit port
	commit_rd_nonzero: assert property (@(posedge clk) disable iff (!arst_n)
		commit.valid |-> (commit.rd != '0))
		else $error("commit shows a write to x0");

	// unknown encodings leave the register file alone
	illegal_no_commit: assert property (@(posedge clk) disable iff (!arst_n)
		illegal |-> !commit.valid)
		else $error("illegal instruction committed a register write");

	// every target keeps word alignment
	pc_aligned: assert property (@(posedge clk) disable iff (!arst_n)
		pc[1:0] == 2'b00)
		else $error("pc lost its word alignment");

	// first edge after release still sees the boot address
	pc_after_reset: assert property (@(posedge clk)
		$rose(arst_n) |-> (pc == RESET_PC))
		else $error("pc differs from the reset address after release");

endmodule

bind core_top core_assertions u_core_assertions (
	.clk     (clk),
	.arst_n  (arst_n),
	.pc      (pc),
	.commit  (commit),
	.illegal (illegal)
);

// File: verification/core_tb.sv
`timescale 1ns/1ps

module core_tb;
	import core_pkg::*;

	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 8;
	// galois taps for x^32 + x^22 + x^2 + x + 1
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
	localparam logic [31:0] LFSR_SEED = 32'd4;
	// addi x0, x0, 0
	localparam word_t NOP = 32'h0000_0013;
	// instruction classes, in draw order
	localparam int CLS_OP_IMM  = 0;
	localparam int CLS_OP      = 1;
	localparam int CLS_LUI     = 2;
	localparam int CLS_AUIPC   = 3;
	localparam int CLS_JAL     = 4;
	localparam int CLS_JALR    = 5;
	localparam int CLS_BRANCH  = 6;
	localparam int CLS_ILLEGAL = 7;
	// model alu operations
	localparam int M_ADD = 0;
	localparam int M_SUB = 1;
	localparam int M_SLT = 2;
	localparam int M_XOR = 3;
	localparam int M_OR  = 4;
	localparam int M_AND = 5;

	logic    clk = 1'b0;
	logic    arst_n;
	word_t   inst;
	word_t   pc;
	commit_t commit;
	logic    illegal;

	logic [31:0] lfsr_state;
	// reference model state
	word_t       m_regs [32];
	word_t       m_pc;
	// current instruction fields
	int          cur_cls;
	int          cur_op;
	reg_idx_t    cur_rd;
	reg_idx_t    cur_rs1;
	reg_idx_t    cur_rs2;
	word_t       cur_imm;
	logic        cur_ne;
	word_t       cur_inst;
	int          test_checks;
	int          test_errors;
	int          total_checks;
	int          total_errors;

	core_top i_dut (
		.clk     (clk),
		.arst_n  (arst_n),
		.inst    (inst),
		.pc      (pc),
		.commit  (commit),
		.illegal (illegal)
	);

	initial begin
		forever begin
			#(CLK_PERIOD / 2);
			clk = ~clk;
		end
	end

	// one lfsr step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic        b;
		r = '0;
		for (int i = 0; i < n; i++) begin
			b = lfsr_state[0];
			lfsr_state = (lfsr_state >> 1) ^ (b ? LFSR_TAPS : 32'd0);
			r = {r[30:0], b};
		end
		return r;
	endfunction

	function automatic word_t alu_model(input int op, input word_t a, input word_t b);
		case (op)
			M_ADD:   return a + b;
			M_SUB:   return a - b;
			M_SLT:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			M_XOR:   return a ^ b;
			M_OR:    return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic [2:0] funct3_of(input int op);
		case (op)
			M_SLT:   return 3'b010;
			M_XOR:   return 3'b100;
			M_OR:    return 3'b110;
			M_AND:   return 3'b111;
			default: return 3'b000;
		endcase
	endfunction

	// rv32i encodings of the supported formats
	function automatic word_t encode();
		case (cur_cls)
			CLS_OP_IMM: return {cur_imm[11:0], cur_rs1, funct3_of(cur_op), cur_rd, 7'b0010011};
			CLS_OP: return {(cur_op == M_SUB) ? 7'h20 : 7'h00, cur_rs2, cur_rs1,
				funct3_of(cur_op), cur_rd, 7'b0110011};
			CLS_LUI:   return {cur_imm[31:12], cur_rd, 7'b0110111};
			CLS_AUIPC: return {cur_imm[31:12], cur_rd, 7'b0010111};
			CLS_JAL: return {cur_imm[20], cur_imm[10:1], cur_imm[11], cur_imm[19:12],
				cur_rd, 7'b1101111};
			CLS_JALR:  return {cur_imm[11:0], cur_rs1, 3'b000, cur_rd, 7'b1100111};
			CLS_BRANCH: return {cur_imm[12], cur_imm[10:5], cur_rs2, cur_rs1, 2'b00, cur_ne,
				cur_imm[4:1], cur_imm[11], 7'b1100011};
			default:   return cur_inst;
		endcase
	endfunction

	// random fields, registers limited to x0..x7
	task automatic draw_fields(input int cls);
		logic [31:0] raw;
		logic [31:0] pick;
		logic [1:0]  low;
		cur_cls = cls;
		cur_rd  = reg_idx_t'(rand_bits(3));
		cur_rs1 = reg_idx_t'(rand_bits(3));
		cur_rs2 = reg_idx_t'(rand_bits(3));
		cur_op  = M_ADD;
		cur_ne  = 1'b0;
		cur_imm = '0;
		case (cls)
			CLS_OP_IMM: begin
				// no subi, so index 1 is skipped
				cur_op  = int'(rand_bits(3) % 5);
				cur_op  = (cur_op == 0) ? M_ADD : cur_op + 1;
				raw     = rand_bits(12);
				cur_imm = {{20{raw[11]}}, raw[11:0]};
			end
			CLS_OP: cur_op = int'(rand_bits(3) % 6);
			CLS_LUI, CLS_AUIPC: begin
				raw     = rand_bits(20);
				cur_imm = {raw[19:0], 12'b0};
			end
			CLS_JAL: begin
				// word offset keeps pc aligned
				raw     = rand_bits(19);
				cur_imm = {{11{raw[18]}}, raw[18:0], 2'b00};
			end
			CLS_JALR: begin
				// sum lands on 0 or 1 mod 4, bit 0 exercises the clear
				raw     = rand_bits(10);
				pick    = rand_bits(1);
				low     = {1'b0, pick[0]} - m_regs[cur_rs1][1:0];
				cur_imm = {{20{raw[9]}}, raw[9:0], low};
			end
			CLS_BRANCH: begin
				raw     = rand_bits(11);
				cur_imm = {{19{raw[10]}}, raw[10:0], 2'b00};
				pick    = rand_bits(2);
				cur_ne  = pick[0];
				// same register half the time, so equal operands are common
				if (pick[1])
					cur_rs2 = cur_rs1;
			end
			default: begin
				raw  = rand_bits(32);
				pick = rand_bits(3);
				case (pick[1:0])
					2'd0: begin
						// opcode outside the supported set
						while (raw[6:0] inside {7'b0010011, 7'b0110011, 7'b0110111,
							7'b0010111, 7'b1101111, 7'b1100111, 7'b1100011})
							raw[6:0] = 7'(rand_bits(7));
					end
					2'd1: begin
						// shifts and sltiu, funct3 001, 011 or 101
						raw[6:0]  = 7'b0010011;
						raw[14:12] = {pick[2], raw[13] & ~pick[2], 1'b1};
					end
					2'd2: begin
						// unknown funct7
						raw[6:0] = 7'b0110011;
						if (raw[31:25] == 7'h00 || raw[31:25] == 7'h20)
							raw[31:25] = 7'h01;
					end
					default: begin
						// blt and friends, or jalr with funct3 not zero
						raw[6:0]   = pick[2] ? 7'b1100011 : 7'b1100111;
						raw[14:12] = (raw[14:13] == 2'b00) ? 3'b010 : raw[14:12];
					end
				endcase
				cur_inst = raw;
			end
		endcase
	endtask

	task automatic check_value(input string name, input word_t got, input word_t exp);
		test_checks++;
		assert (got === exp) else begin
			$display("[ERROR] %0t %s: got %h expected %h", $time, name, got, exp);
			test_errors++;
		end
	endtask

	task automatic check_outputs(input logic exp_valid, input word_t exp_data,
		input logic exp_illegal);
		check_value("pc", pc, m_pc);
		check_value("commit.valid", word_t'(commit.valid), word_t'(exp_valid));
		check_value("illegal", word_t'(illegal), word_t'(exp_illegal));
		if (exp_valid) begin
			check_value("commit.rd", word_t'(commit.rd), word_t'(cur_rd));
			check_value("commit.data", commit.data, exp_data);
		end
	endtask

	// bounded wait for the next falling edge
	task automatic wait_fall();
		int n;
		n = 0;
		do begin
			@(clk);
			n++;
		end while (clk !== 1'b0 && n < 4);
		if (clk !== 1'b0) begin
			$display("timeout: no falling clock edge");
			$display("Test FAILED");
			$finish;
		end
	endtask

	// drive one instruction, check it, then step the model
	task automatic exec_one();
		word_t a;
		word_t b;
		word_t exp_data;
		word_t exp_next;
		logic  exp_valid;
		logic  exp_illegal;
		wait_fall();
		inst        = encode();
		a           = m_regs[cur_rs1];
		b           = m_regs[cur_rs2];
		exp_valid   = (cur_rd != '0);
		exp_illegal = 1'b0;
		exp_data    = m_pc + 32'd4;
		exp_next    = m_pc + 32'd4;
		case (cur_cls)
			CLS_OP_IMM: exp_data = alu_model(cur_op, a, cur_imm);
			CLS_OP:     exp_data = alu_model(cur_op, a, b);
			CLS_LUI:    exp_data = cur_imm;
			CLS_AUIPC:  exp_data = m_pc + cur_imm;
			CLS_JAL:    exp_next = m_pc + cur_imm;
			CLS_JALR:   exp_next = (a + cur_imm) & ~32'd1;
			CLS_BRANCH: begin
				exp_valid = 1'b0;
				if ((a == b) != cur_ne)
					exp_next = m_pc + cur_imm;
			end
			default: begin
				exp_valid   = 1'b0;
				exp_illegal = 1'b1;
			end
		endcase
		// sample just ahead of the rising edge
		#(CLK_PERIOD / 2 - 2);
		check_outputs(exp_valid, exp_data, exp_illegal);
		if (exp_valid)
			m_regs[cur_rd] = exp_data;
		m_pc = exp_next;
	endtask

	task automatic run_class(input int cls);
		draw_fields(cls);
		exec_one();
	endtask

	task automatic end_test(input string name);
		$display("test %s: %0d checks, %0d errors", name, test_checks, test_errors);
		total_checks += test_checks;
		total_errors += test_errors;
		test_checks  = 0;
		test_errors  = 0;
	endtask

	initial begin
		logic [31:0] pick;
		lfsr_state   = LFSR_SEED;
		arst_n       = 1'b0;
		inst         = NOP;
		m_pc         = RESET_PC;
		test_checks  = 0;
		test_errors  = 0;
		total_checks = 0;
		total_errors = 0;
		for (int i = 0; i < 32; i++)
			m_regs[i] = '0;
		// reset held, nop keeps commit and illegal low
		// release comes on the last falling edge of the reset window
		for (int i = 0; i < RESET_CYCLES - 1; i++) begin
			wait_fall();
			#(CLK_PERIOD / 2 - 2);
			check_outputs(1'b0, '0, 1'b0);
		end
		wait_fall();
		arst_n = 1'b1;
		#(CLK_PERIOD / 2 - 2);
		check_outputs(1'b0, '0, 1'b0);
		// the nop steps pc on the first edge
		m_pc = RESET_PC + 32'd4;
		end_test("reset");
		for (int i = 0; i < 300; i++) begin
			pick = rand_bits(1);
			run_class(pick[0] ? CLS_OP : CLS_OP_IMM);
		end
		end_test("alu");
		for (int i = 0; i < 60; i++) begin
			pick = rand_bits(1);
			run_class(pick[0] ? CLS_AUIPC : CLS_LUI);
		end
		end_test("upper");
		for (int i = 0; i < 60; i++) begin
			pick = rand_bits(1);
			run_class(pick[0] ? CLS_JALR : CLS_JAL);
		end
		end_test("jump");
		repeat (80)
			run_class(CLS_BRANCH);
		end_test("branch");
		// illegal, then a write to x0, then a read of x0
		repeat (40) begin
			run_class(CLS_ILLEGAL);
			draw_fields(CLS_OP_IMM);
			cur_rd = '0;
			exec_one();
			draw_fields(CLS_OP);
			cur_op  = M_ADD;
			cur_rs1 = '0;
			cur_rs2 = '0;
			if (cur_rd == '0)
				cur_rd = 5'd1;
			exec_one();
		end
		end_test("illegal");
		repeat (200)
			run_class(int'(rand_bits(3)));
		end_test("mixed");
		$display("total: %0d checks, %0d errors", total_checks, total_errors);
		if (total_errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// File: verilog.f
common/core_pkg.sv
source/pc_unit.sv
decode/inst_decoder.sv
source/register_file.sv
execute/execute_unit.sv
source/core_top.sv
verification/core_assertions.sv
verification/core_tb.sv
